// File: rv32_pkg.sv
// Core widths, memory sizes, reset PC and the decode enums
package rv32_pkg;

    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int NUM_REGS    = 32;
    localparam int DMEM_WORDS  = 64;
    localparam int DMEM_ADDR_W = 6;   // Word index, taken from address bits 7:2

    localparam logic [XLEN-1:0] RESET_PC = '0;

    // Major opcodes, instruction bits 6:0
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    // Encoded as the branch funct3
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } branch_cond_e;

    typedef enum logic [1:0] {
        NPC_SEQ    = 2'd0,
        NPC_BRANCH = 2'd1,
        NPC_JAL    = 2'd2,
        NPC_JALR   = 2'd3
    } next_pc_e;

    typedef enum logic [2:0] {
        WB_ALU    = 3'd0,
        WB_LOAD   = 3'd1,
        WB_PC4    = 3'd2,
        WB_IMM    = 3'd3,   // LUI
        WB_PC_IMM = 3'd4    // AUIPC
    } wb_sel_e;

endpackage

// File: rv32_fetch.sv
// Program counter register, PC adders and next-PC selection
module rv32_fetch import rv32_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  next_pc_e        next_pc_sel,
    input  logic            cond_true,
    input  logic [XLEN-1:0] imm,
    input  logic [XLEN-1:0] alu_result,
    output logic [XLEN-1:0] pc,
    output logic [XLEN-1:0] pc_plus_4,
    output logic [XLEN-1:0] pc_plus_imm
);

    logic [XLEN-1:0] next_pc;

    assign pc_plus_4   = pc + 32'd4;
    assign pc_plus_imm = pc + imm;    // Branch, JAL and AUIPC target

    always_comb begin
        case (next_pc_sel)
            NPC_BRANCH: begin
                next_pc = cond_true ? pc_plus_imm : pc_plus_4;
            end
            NPC_JAL: begin
                next_pc = pc_plus_imm;
            end
            NPC_JALR: begin
                // rs1 + imm from the ALU, low bit dropped
                next_pc = {alu_result[XLEN-1:1], 1'b0};
            end
            default: begin
                next_pc = pc_plus_4;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

endmodule

// File: rv32_control.sv
// Instruction field extraction and main decoder
module rv32_control import rv32_pkg::*; (
    input  logic [XLEN-1:0]       instruction,
    output logic [REG_ADDR_W-1:0] rs1_addr,
    output logic [REG_ADDR_W-1:0] rs2_addr,
    output logic [REG_ADDR_W-1:0] rd_addr,
    output alu_op_e               alu_op,
    output logic                  use_imm,
    output branch_cond_e          branch_cond,
    output next_pc_e              next_pc_sel,
    output wb_sel_e               wb_sel,
    output logic                  reg_wen,
    output logic                  mem_wen
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       alt_bit;
    alu_op_e    arith_op;

    assign opcode   = opcode_e'(instruction[6:0]);
    assign funct3   = instruction[14:12];
    assign alt_bit  = instruction[30];   // SUB and SRA/SRAI select
    assign rs1_addr = instruction[19:15];
    assign rs2_addr = instruction[24:20];
    assign rd_addr  = instruction[11:7];

    assign branch_cond = branch_cond_e'(funct3);

    // Shared by register and immediate ALU forms
    always_comb begin
        case (funct3)
            3'b000:  arith_op = (opcode == OP_REG && alt_bit) ? ALU_SUB : ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = alt_bit ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        alu_op      = ALU_ADD;
        use_imm     = 1'b0;
        next_pc_sel = NPC_SEQ;
        wb_sel      = WB_ALU;
        reg_wen     = 1'b0;
        mem_wen     = 1'b0;
        case (opcode)
            OP_REG: begin
                alu_op  = arith_op;
                reg_wen = 1'b1;
            end
            OP_IMM: begin
                alu_op  = arith_op;
                use_imm = 1'b1;
                reg_wen = 1'b1;
            end
            OP_LOAD: begin
                use_imm = 1'b1;          // Address is rs1 + imm
                wb_sel  = WB_LOAD;
                reg_wen = 1'b1;
            end
            OP_STORE: begin
                use_imm = 1'b1;
                mem_wen = 1'b1;
            end
            OP_BRANCH: begin
                next_pc_sel = NPC_BRANCH;
            end
            OP_JAL: begin
                next_pc_sel = NPC_JAL;
                wb_sel      = WB_PC4;
                reg_wen     = 1'b1;
            end
            OP_JALR: begin
                use_imm     = 1'b1;
                next_pc_sel = NPC_JALR;
                wb_sel      = WB_PC4;
                reg_wen     = 1'b1;
            end
            OP_LUI: begin
                wb_sel  = WB_IMM;
                reg_wen = 1'b1;
            end
            OP_AUIPC: begin
                wb_sel  = WB_PC_IMM;
                reg_wen = 1'b1;
            end
            default: ;                   // Unknown opcode is a no-op
        endcase
    end

endmodule

// File: rv32_imm_gen.sv
// Immediate extraction and sign extension for all formats
module rv32_imm_gen import rv32_pkg::*; (
    input  logic [XLEN-1:0] instruction,
    output logic [XLEN-1:0] imm
);

    opcode_e opcode;
    logic    sign;

    assign opcode = opcode_e'(instruction[6:0]);
    assign sign   = instruction[31];

    always_comb begin
        case (opcode)
            OP_IMM, OP_LOAD, OP_JALR: begin
                imm = {{20{sign}}, instruction[31:20]};
            end
            OP_STORE: begin
                imm = {{20{sign}}, instruction[31:25], instruction[11:7]};
            end
            OP_BRANCH: begin
                imm = {{19{sign}}, sign, instruction[7], instruction[30:25],
                       instruction[11:8], 1'b0};
            end
            OP_LUI, OP_AUIPC: begin
                imm = {instruction[31:12], 12'b0};
            end
            OP_JAL: begin
                imm = {{11{sign}}, sign, instruction[19:12], instruction[20],
                       instruction[30:21], 1'b0};
            end
            default: begin
                imm = '0;   // R-type and unknown opcodes
            end
        endcase
    end

endmodule

// File: rv32_regfile.sv
// Register file, two read ports and one write port, x0 reads zero
module rv32_regfile import rv32_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [REG_ADDR_W-1:0] rs1_addr,
    input  logic [REG_ADDR_W-1:0] rs2_addr,
    input  logic [REG_ADDR_W-1:0] rd_addr,
    input  logic                  wen,
    input  logic [XLEN-1:0]       wdata,
    output logic [XLEN-1:0]       rs1_data,
    output logic [XLEN-1:0]       rs2_data
);

    logic [XLEN-1:0] regs [NUM_REGS];

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && rd_addr != '0) begin   // Writes to x0 dropped
            regs[rd_addr] <= wdata;
        end
    end

endmodule

// File: rv32_alu.sv
// Operand B select, ALU operations and branch comparator
module rv32_alu import rv32_pkg::*; (
    input  logic [XLEN-1:0] rs1_data,
    input  logic [XLEN-1:0] rs2_data,
    input  logic [XLEN-1:0] imm,
    input  logic            use_imm,
    input  alu_op_e         alu_op,
    input  branch_cond_e    branch_cond,
    output logic [XLEN-1:0] alu_result,
    output logic            cond_true
);

    logic [XLEN-1:0] op_b;
    logic [4:0]      shamt;
    logic            lt_signed;
    logic            lt_unsigned;

    assign op_b  = use_imm ? imm : rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADD:  alu_result = rs1_data + op_b;
            ALU_SUB:  alu_result = rs1_data - op_b;
            ALU_SLL:  alu_result = rs1_data << shamt;
            ALU_SLT:  alu_result = {31'b0, $signed(rs1_data) < $signed(op_b)};
            ALU_SLTU: alu_result = {31'b0, rs1_data < op_b};
            ALU_XOR:  alu_result = rs1_data ^ op_b;
            ALU_SRL:  alu_result = rs1_data >> shamt;
            ALU_SRA:  alu_result = $signed(rs1_data) >>> shamt;
            ALU_OR:   alu_result = rs1_data | op_b;
            ALU_AND:  alu_result = rs1_data & op_b;
            default:  alu_result = '0;
        endcase
    end

    // Compares always use rs2, never the immediate
    assign lt_signed   = $signed(rs1_data) < $signed(rs2_data);
    assign lt_unsigned = rs1_data < rs2_data;

    always_comb begin
        case (branch_cond)
            BR_EQ:   cond_true = (rs1_data == rs2_data);
            BR_NE:   cond_true = (rs1_data != rs2_data);
            BR_LT:   cond_true = lt_signed;
            BR_GE:   cond_true = !lt_signed;
            BR_LTU:  cond_true = lt_unsigned;
            BR_GEU:  cond_true = !lt_unsigned;
            default: cond_true = 1'b0;
        endcase
    end

endmodule

// File: rv32_mem_writeback.sv
// Word data memory and writeback result select
module rv32_mem_writeback import rv32_pkg::*; (
    input  logic            clk,
    input  logic            mem_wen,
    input  logic [XLEN-1:0] alu_result,
    input  logic [XLEN-1:0] rs2_data,
    input  logic [XLEN-1:0] imm,
    input  logic [XLEN-1:0] pc_plus_4,
    input  logic [XLEN-1:0] pc_plus_imm,
    input  wb_sel_e         wb_sel,
    output logic [XLEN-1:0] wb_data
);

    logic [XLEN-1:0]        dmem [DMEM_WORDS];
    logic [DMEM_ADDR_W-1:0] word_idx;
    logic [XLEN-1:0]        load_word;

    assign word_idx  = alu_result[DMEM_ADDR_W+1:2];   // Byte offset ignored
    assign load_word = dmem[word_idx];

    always_ff @(posedge clk) begin
        if (mem_wen) begin
            dmem[word_idx] <= rs2_data;
        end
    end

    always_comb begin
        case (wb_sel)
            WB_LOAD:   wb_data = load_word;
            WB_PC4:    wb_data = pc_plus_4;
            WB_IMM:    wb_data = imm;
            WB_PC_IMM: wb_data = pc_plus_imm;
            default:   wb_data = alu_result;
        endcase
    end

endmodule

// File: rv32_core.sv
// Single-cycle RV32I core top level
module rv32_core import rv32_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    output logic [XLEN-1:0]       imem_addr,
    input  logic [XLEN-1:0]       imem_data,
    output logic                  wb_en,
    output logic [REG_ADDR_W-1:0] wb_addr,
    output logic [XLEN-1:0]       wb_data
);

    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       pc_plus_4;
    logic [XLEN-1:0]       pc_plus_imm;
    logic [XLEN-1:0]       imm;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic [XLEN-1:0]       alu_result;
    logic [XLEN-1:0]       result;
    logic                  cond_true;
    logic                  use_imm;
    logic                  reg_wen;
    logic                  mem_wen;
    alu_op_e               alu_op;
    branch_cond_e          branch_cond;
    next_pc_e              next_pc_sel;
    wb_sel_e               wb_sel;

    assign imem_addr = pc;
    assign wb_en     = reg_wen;
    assign wb_addr   = rd_addr;
    assign wb_data   = result;

    rv32_fetch fetch_i (
        .clk         (clk),
        .reset       (reset),
        .next_pc_sel (next_pc_sel),
        .cond_true   (cond_true),
        .imm         (imm),
        .alu_result  (alu_result),
        .pc          (pc),
        .pc_plus_4   (pc_plus_4),
        .pc_plus_imm (pc_plus_imm)
    );

    rv32_control control_i (
        .instruction (imem_data),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .rd_addr     (rd_addr),
        .alu_op      (alu_op),
        .use_imm     (use_imm),
        .branch_cond (branch_cond),
        .next_pc_sel (next_pc_sel),
        .wb_sel      (wb_sel),
        .reg_wen     (reg_wen),
        .mem_wen     (mem_wen)
    );

    rv32_imm_gen imm_gen_i (
        .instruction (imem_data),
        .imm         (imm)
    );

    rv32_regfile regfile_i (
        .clk      (clk),
        .reset    (reset),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rd_addr  (rd_addr),
        .wen      (reg_wen),
        .wdata    (result),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    rv32_alu alu_i (
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .imm         (imm),
        .use_imm     (use_imm),
        .alu_op      (alu_op),
        .branch_cond (branch_cond),
        .alu_result  (alu_result),
        .cond_true   (cond_true)
    );

    rv32_mem_writeback mem_wb_i (
        .clk         (clk),
        .mem_wen     (mem_wen),
        .alu_result  (alu_result),
        .rs2_data    (rs2_data),
        .imm         (imm),
        .pc_plus_4   (pc_plus_4),
        .pc_plus_imm (pc_plus_imm),
        .wb_sel      (wb_sel),
        .wb_data     (result)
    );

endmodule

// File: rv32_core_assert.sv
// Concurrent assertions on the core's fetch address and writeback port
module rv32_core_assert import rv32_pkg::*; (
    input logic            clk,
    input logic            reset,
    input logic [XLEN-1:0] imem_addr,
    input logic            wb_en,
    input logic [XLEN-1:0] wb_data
);

    pc_aligned: assert property (@(posedge clk) imem_addr[1:0] == 2'b00)
        else $error("imem_addr is not word aligned: %h", imem_addr);

    pc_in_reset: assert property (@(posedge clk) reset |-> imem_addr == RESET_PC)
        else $error("imem_addr is %h while reset is high", imem_addr);

    // Writeback value must be fully known when it is written
    wb_known: assert property (@(posedge clk) disable iff (reset)
        wb_en |-> !$isunknown(wb_data))
        else $error("wb_data has unknown bits while wb_en is high");

endmodule

bind rv32_core rv32_core_assert assert_i (
    .clk       (clk),
    .reset     (reset),
    .imem_addr (imem_addr),
    .wb_en     (wb_en),
    .wb_data   (wb_data)
);

// File: tb_rv32_core.sv
// Testbench for rv32_core with instruction memory model, encoders, directed tests and watchdog
module tb_rv32_core import rv32_pkg::*; ();

    localparam int TOTAL_STEPS = 71;
    localparam int NUM_RUNS    = 7;
    localparam int PROG_WORDS  = 64;
    localparam logic [31:0] NOP = 32'h0000_0013;   // addi x0, x0, 0

    logic                  clk;
    logic                  reset;
    logic [XLEN-1:0]       imem_addr;
    logic [XLEN-1:0]       imem_data;
    logic                  wb_en;
    logic [REG_ADDR_W-1:0] wb_addr;
    logic [XLEN-1:0]       wb_data;

    logic [31:0] prog [PROG_WORDS];
    int          exp_pc [$];
    logic        exp_en [$];
    int          exp_rd [$];
    logic [31:0] exp_val [$];
    string       cur_test;
    int          errors;
    int          tests_run;
    int          tests_failed;

    rv32_core dut_i (
        .clk       (clk),
        .reset     (reset),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .wb_en     (wb_en),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Instruction encoders for the RV32I base formats
    function automatic logic [31:0] r_type(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OP_REG};
    endfunction

    function automatic logic [31:0] i_type(opcode_e op, int imm, int rs1, int f3, int rd);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] s_type(int imm, int rs2, int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] b_type(int f3, int rs1, int rs2, int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] u_type(opcode_e op, int imm20, int rd);
        return {imm20[19:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] j_type(int imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OP_JAL};
    endfunction

    function automatic logic [31:0] addi(int rd, int rs1, int imm);
        return i_type(OP_IMM, imm, rs1, 0, rd);
    endfunction

    task automatic check(input string what, input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s %s expected %h actual %h", cur_test, what, expected, actual);
            errors++;
        end
    endtask

    task automatic put(input int addr, input logic [31:0] instr);
        prog[addr / 4] = instr;
    endtask

    // Expected PC and register write of one retired instruction
    task automatic step(input int pc, input logic en, input int rd, input logic [31:0] val);
        exp_pc.push_back(pc);
        exp_en.push_back(en);
        exp_rd.push_back(rd);
        exp_val.push_back(val);
    endtask

    task automatic expect_instr(input int addr, input logic [31:0] instr, input logic en,
                                input int rd, input logic [31:0] val);
        put(addr, instr);
        step(addr, en, rd, val);
    endtask

    task automatic clear_program();
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog[i] = NOP;
        end
    endtask

    task automatic refresh_fetch();
        imem_data = prog[imem_addr[7:2]];
    endtask

    task automatic run_program();
        reset     = 1'b1;
        imem_data = NOP;
        repeat (5) @(posedge clk);
        #1 reset = 1'b0;
        refresh_fetch();
        for (int i = 0; i < exp_pc.size(); i++) begin
            @(negedge clk);
            check("pc", 32'(exp_pc[i]), imem_addr);
            check("wb_en", {31'b0, exp_en[i]}, {31'b0, wb_en});
            if (exp_en[i]) begin
                check("wb_addr", 32'(exp_rd[i]), {27'b0, wb_addr});
                check("wb_data", exp_val[i], wb_data);
            end
            @(posedge clk);
            #1 refresh_fetch();
        end
        exp_pc.delete();
        exp_en.delete();
        exp_rd.delete();
        exp_val.delete();
        clear_program();
    endtask

    task automatic finish_test(input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("PASS %s", cur_test);
        end else begin
            tests_failed++;
            $display("FAIL %s (%0d mismatches)", cur_test, errors - errors_before);
        end
    endtask

    task automatic test_alu();
        int e0;
        e0 = errors;
        cur_test = "alu";
        expect_instr(0, addi(1, 0, -7), 1, 1, 32'hFFFF_FFF9);
        expect_instr(4, addi(2, 0, 3), 1, 2, 32'h3);
        expect_instr(8, r_type(0, 2, 1, 0, 3), 1, 3, 32'hFFFF_FFFC);
        expect_instr(12, r_type(32, 1, 2, 0, 4), 1, 4, 32'hA);
        expect_instr(16, r_type(0, 2, 2, 1, 5), 1, 5, 32'h18);
        expect_instr(20, r_type(0, 2, 1, 2, 6), 1, 6, 32'h1);
        expect_instr(24, r_type(0, 2, 1, 3, 7), 1, 7, 32'h0);
        expect_instr(28, r_type(0, 2, 1, 4, 8), 1, 8, 32'hFFFF_FFFA);
        expect_instr(32, r_type(0, 2, 1, 5, 9), 1, 9, 32'h1FFF_FFFF);
        expect_instr(36, r_type(32, 2, 1, 5, 10), 1, 10, 32'hFFFF_FFFF);
        expect_instr(40, r_type(0, 2, 1, 6, 11), 1, 11, 32'hFFFF_FFFB);
        expect_instr(44, r_type(0, 2, 1, 7, 12), 1, 12, 32'h1);
        expect_instr(48, i_type(OP_IMM, -6, 1, 2, 13), 1, 13, 32'h1);
        expect_instr(52, i_type(OP_IMM, -1, 2, 3, 14), 1, 14, 32'h1);
        expect_instr(56, i_type(OP_IMM, -1, 1, 4, 15), 1, 15, 32'h6);
        expect_instr(60, i_type(OP_IMM, 'h70, 2, 6, 16), 1, 16, 32'h73);
        expect_instr(64, i_type(OP_IMM, 'hF0, 1, 7, 17), 1, 17, 32'hF0);
        expect_instr(68, i_type(OP_IMM, 4, 2, 1, 18), 1, 18, 32'h30);
        expect_instr(72, i_type(OP_IMM, 28, 1, 5, 19), 1, 19, 32'hF);
        expect_instr(76, i_type(OP_IMM, 'h401, 1, 5, 20), 1, 20, 32'hFFFF_FFFC);  // SRAI
        expect_instr(80, addi(0, 0, 5), 1, 0, 32'h5);
        expect_instr(84, r_type(0, 2, 0, 0, 21), 1, 21, 32'h3);  // x0 still zero
        run_program();
        finish_test(e0);
    endtask

    task automatic test_upper();
        int e0;
        e0 = errors;
        cur_test = "lui_auipc";
        expect_instr(0, u_type(OP_LUI, 'h12345, 1), 1, 1, 32'h1234_5000);
        expect_instr(4, u_type(OP_AUIPC, 'h1, 2), 1, 2, 32'h0000_1004);
        expect_instr(8, u_type(OP_LUI, 'hFFFFF, 3), 1, 3, 32'hFFFF_F000);
        expect_instr(12, u_type(OP_AUIPC, 'h80000, 4), 1, 4, 32'h8000_000C);
        run_program();
        finish_test(e0);
    endtask

    task automatic test_load_store();
        int e0;
        e0 = errors;
        cur_test = "load_store";
        expect_instr(0, addi(1, 0, 'h55), 1, 1, 32'h55);
        expect_instr(4, addi(2, 0, -2), 1, 2, 32'hFFFF_FFFE);
        expect_instr(8, addi(3, 0, 16), 1, 3, 32'h10);
        expect_instr(12, s_type(0, 1, 3), 0, 0, 32'h0);
        expect_instr(16, s_type(4, 2, 3), 0, 0, 32'h0);
        expect_instr(20, s_type(-16, 2, 3), 0, 0, 32'h0);
        expect_instr(24, i_type(OP_LOAD, 0, 3, 2, 4), 1, 4, 32'h55);
        expect_instr(28, i_type(OP_LOAD, 4, 3, 2, 5), 1, 5, 32'hFFFF_FFFE);
        expect_instr(32, i_type(OP_LOAD, -16, 3, 2, 6), 1, 6, 32'hFFFF_FFFE);
        expect_instr(36, s_type(4, 1, 3), 0, 0, 32'h0);   // Overwrite
        expect_instr(40, i_type(OP_LOAD, 4, 3, 2, 7), 1, 7, 32'h55);
        expect_instr(44, i_type(OP_LOAD, 0, 0, 2, 8), 1, 8, 32'hFFFF_FFFE);
        expect_instr(48, i_type(OP_LOAD, 16, 0, 2, 9), 1, 9, 32'h55);
        run_program();
        finish_test(e0);
    endtask

    // Each branch jumps over one marker; the marker at pc+4 runs only when not taken
    task automatic test_branches();
        int e0;
        int f3_list [6];
        e0 = errors;
        cur_test = "branches";
        f3_list = '{0, 1, 4, 5, 6, 7};
        expect_instr(0, addi(1, 0, -1), 1, 1, 32'hFFFF_FFFF);
        expect_instr(4, addi(2, 0, 1), 1, 2, 32'h1);
        for (int i = 0; i < 6; i++) begin
            int base;
            base = 8 + i * 16;
            // Taken case first, then not taken, from the chosen operands
            case (f3_list[i])
                0: begin
                    put(base, b_type(0, 1, 1, 8));
                    put(base + 8, b_type(0, 1, 2, 8));
                end
                1: begin
                    put(base, b_type(1, 1, 2, 8));
                    put(base + 8, b_type(1, 2, 2, 8));
                end
                4: begin
                    put(base, b_type(4, 1, 2, 8));
                    put(base + 8, b_type(4, 2, 1, 8));
                end
                5: begin
                    put(base, b_type(5, 2, 1, 8));
                    put(base + 8, b_type(5, 1, 2, 8));
                end
                6: begin
                    put(base, b_type(6, 2, 1, 8));
                    put(base + 8, b_type(6, 1, 2, 8));
                end
                default: begin
                    put(base, b_type(7, 1, 2, 8));
                    put(base + 8, b_type(7, 2, 1, 8));
                end
            endcase
            put(base + 4, addi(5, 0, 2 * i + 1));
            put(base + 12, addi(5, 0, 2 * i + 2));
            step(base, 0, 0, 32'h0);
            step(base + 8, 0, 0, 32'h0);
            step(base + 12, 1, 5, 32'(2 * i + 2));
        end
        expect_instr(104, addi(6, 0, 99), 1, 6, 32'd99);
        run_program();
        finish_test(e0);
    endtask

    task automatic test_jumps();
        int e0;
        e0 = errors;
        cur_test = "jumps";
        expect_instr(0, j_type(12, 1), 1, 1, 32'd4);
        put(4, addi(5, 0, 1));
        put(8, addi(5, 0, 2));
        expect_instr(12, addi(2, 0, 33), 1, 2, 32'd33);
        expect_instr(16, i_type(OP_JALR, 4, 2, 0, 3), 1, 3, 32'd20);  // Target 37 becomes 36
        put(20, addi(5, 0, 3));
        put(32, addi(5, 0, 4));
        expect_instr(36, addi(4, 0, 7), 1, 4, 32'd7);
        expect_instr(40, j_type(-40, 0), 1, 0, 32'd44);
        step(0, 1, 1, 32'd4);
        run_program();
        finish_test(e0);
    endtask

    task automatic test_reset_restart();
        int e0;
        e0 = errors;
        cur_test = "reset_restart";
        expect_instr(0, addi(1, 0, 5), 1, 1, 32'd5);
        expect_instr(4, addi(2, 0, 6), 1, 2, 32'd6);
        put(8, addi(3, 0, 7));
        run_program();
        // Second program starts under a fresh reset, mid-way through the first
        expect_instr(0, r_type(0, 2, 1, 0, 3), 1, 3, 32'h0);
        expect_instr(4, r_type(0, 2, 1, 6, 4), 1, 4, 32'h0);
        run_program();
        finish_test(e0);
    endtask

    initial begin
        int limit;
        limit = (TOTAL_STEPS + NUM_RUNS * 6) * 100 + 5000;
        #(limit);
        $display("Watchdog expired: the tests did not finish in time");
        $display("Something failed");
        $finish;
    end

    initial begin
        reset        = 1'b1;
        imem_data    = NOP;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        clear_program();
        test_alu();
        test_upper();
        test_load_store();
        test_branches();
        test_jumps();
        test_reset_restart();
        $display("Tests run %0d, failed %0d, mismatches %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: rv32_core.f
rv32_pkg.sv
rv32_fetch.sv
rv32_control.sv
rv32_imm_gen.sv
rv32_regfile.sv
rv32_alu.sv
rv32_mem_writeback.sv
rv32_core.sv
rv32_core_assert.sv
tb_rv32_core.sv

// File: Makefile
# Verilator simulation of the single-cycle RV32I core

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, fail unless the pass message appears"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f rv32_core.f --top-module tb_rv32_core \
		-o sim_rv32_core
	@out=$$(./obj_dir/sim_rv32_core); \
	echo "$$out"; \
	echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir
